// ==== Makefile ====
# Verilator build and run of the acquisition testbench

TOP = tb_scope_acq
LOG = sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f scope_acq_top.f -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "Simulation finished: FAIL" >> $(LOG)
	cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// ==== acq_fifo/acq_fifo.sv ====
/*
  sample FIFO
  circular buffer of sample and time stamp pairs; a write into a
  full buffer is dropped and counted
*/

`default_nettype none

module acq_fifo #(
  parameter int unsigned FIFO_DEPTH = 16
) (
  input  wire                    adc_clk,
  input  wire                    top_rst,
  input  wire                    wr_vld_i,
  input  wire acq_pkg::sample_t  wr_sample_i,
  input  wire acq_pkg::ts_t      wr_ts_i,
  input  wire                    rd_pop_i,
  output logic                   rd_empty_o,
  output acq_pkg::sample_t       rd_sample_o,
  output acq_pkg::ts_t           rd_ts_o,
  output acq_pkg::ovf_cnt_t      ovf_cnt_o
);

  localparam int unsigned AW = $clog2(FIFO_DEPTH);

  acq_pkg::sample_t smp_mem [FIFO_DEPTH];
  acq_pkg::ts_t     ts_mem  [FIFO_DEPTH];

  // one extra wrap bit on each pointer
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        full;
  logic        do_pop;
  logic        do_wr;
  logic        drop;

  ////////////////////////////////////////
  // status
  ////////////////////////////////////////

  assign rd_empty_o = (wr_ptr == rd_ptr);
  assign full       = (wr_ptr[AW] != rd_ptr[AW]) &&
                      (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign do_pop     = rd_pop_i && !rd_empty_o;
  // pop in the same cycle frees the slot
  assign do_wr      = wr_vld_i && (!full || do_pop);
  assign drop       = wr_vld_i && !do_wr;

  ////////////////////////////////////////
  // pointers and overflow count
  ////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      ovf_cnt_o <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // holds at all ones
      if (drop && (ovf_cnt_o != '1)) begin
        ovf_cnt_o <= ovf_cnt_o + acq_pkg::ovf_cnt_t'(1);
      end
    end
  end

  // storage
  always_ff @(posedge adc_clk) begin
    if (do_wr) begin
      smp_mem[wr_ptr[AW-1:0]] <= wr_sample_i;
      ts_mem[wr_ptr[AW-1:0]]  <= wr_ts_i;
    end
  end

  // head word shown straight from the array
  assign rd_sample_o = smp_mem[rd_ptr[AW-1:0]];
  assign rd_ts_o     = ts_mem[rd_ptr[AW-1:0]];

  // readout must wait for data
  a_no_pop_empty: assert property (@(posedge adc_clk) disable iff (top_rst)
    rd_pop_i |-> !rd_empty_o);

endmodule

`default_nettype wire

// ==== adc_calib/adc_calib.sv ====
/*
  ADC channel front end
  pin register with code conversion, gain and offset calibration with
  saturation, decimation and time stamping of every kept sample
*/

`default_nettype none

module adc_calib (
  input  wire                    adc_clk,
  input  wire                    top_rst,
  input  wire [15:0]             adc_dat_i,
  input  wire                    acq_en_i,
  input  wire acq_pkg::dec_t     dec_i,
  input  wire acq_pkg::cal_mul_t cal_mul_i,
  input  wire acq_pkg::cal_sum_t cal_sum_i,
  output logic                   smp_vld_o,
  output acq_pkg::sample_t       smp_data_o,
  output acq_pkg::ts_t           smp_ts_o
);

  // product and sum widths
  localparam int PRD_W = $bits(acq_pkg::sample_t) + $bits(acq_pkg::cal_mul_t);
  localparam int SUM_W = PRD_W + 1;

  acq_pkg::adc_raw_t       pin_fld;
  acq_pkg::dec_t           dec_eff;
  acq_pkg::dec_t           dec_cnt;
  logic                    keep;
  acq_pkg::ts_t            ts_cnt;
  acq_pkg::sample_t        adc_r;
  acq_pkg::ts_t            ts_s1;
  acq_pkg::ts_t            ts_s2;
  logic                    vld_s1;
  logic                    vld_s2;
  logic signed [PRD_W-1:0] mul_r;
  logic signed [SUM_W-1:0] sum;
  acq_pkg::sample_t        sat;

  ////////////////////////////////////////
  // time stamp and decimation
  ////////////////////////////////////////

  assign pin_fld = adc_dat_i[15:2];
  assign dec_eff = (dec_i == '0) ? acq_pkg::dec_t'(1) : dec_i;
  // first enabled cycle always keeps
  assign keep    = acq_en_i && (dec_cnt == '0);

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      ts_cnt  <= '0;
      dec_cnt <= '0;
    end else begin
      ts_cnt <= ts_cnt + acq_pkg::ts_t'(1);
      // parked at zero while disabled
      if (!acq_en_i) begin
        dec_cnt <= '0;
      end else if (keep) begin
        dec_cnt <= dec_eff - acq_pkg::dec_t'(1);
      end else begin
        dec_cnt <= dec_cnt - acq_pkg::dec_t'(1);
      end
    end
  end

  ////////////////////////////////////////
  // three stage pipeline
  ////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      vld_s1    <= 1'b0;
      vld_s2    <= 1'b0;
      smp_vld_o <= 1'b0;
    end else begin
      vld_s1    <= keep;
      vld_s2    <= vld_s1;
      smp_vld_o <= vld_s2;
    end
  end

  always_ff @(posedge adc_clk) begin
    // offset binary, inverted: keep msb, flip the rest
    adc_r      <= acq_pkg::sample_t'({pin_fld[13], ~pin_fld[12:0]});
    ts_s1      <= ts_cnt;
    // signed gain
    mul_r      <= PRD_W'(adc_r) * PRD_W'(cal_mul_i);
    ts_s2      <= ts_s1;
    smp_data_o <= sat;
    smp_ts_o   <= ts_s2;
  end

  // scale back, add offset in the wide sum
  assign sum = SUM_W'(mul_r >>> acq_pkg::CAL_SHIFT) + SUM_W'(cal_sum_i);

  always_comb begin
    if (sum > SUM_W'(acq_pkg::SAMPLE_MAX)) begin
      sat = acq_pkg::SAMPLE_MAX;
    end else if (sum < SUM_W'(acq_pkg::SAMPLE_MIN)) begin
      sat = acq_pkg::SAMPLE_MIN;
    end else begin
      sat = acq_pkg::sample_t'(sum);
    end
  end

  // spacing of strobes follows dec of the capture cycle
  a_dec_gap: assert property (@(posedge adc_clk) disable iff (top_rst)
    (smp_vld_o && ($past(dec_i, 3) > acq_pkg::dec_t'(1))) |=> !smp_vld_o);

endmodule

`default_nettype wire

// ==== common/acq_pkg.sv ====
/*
  acquisition package
  sample, calibration, time stamp and count types shared by the
  ADC channel, the sample FIFO and the readout port
*/

`default_nettype none

package acq_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // converter resolution in use
  localparam int SMP_W = 14;
  // multiplier width as in the linear block
  localparam int MUL_W = 16;

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////

  // raw code from pins 15..2
  typedef logic [SMP_W-1:0] adc_raw_t;
  // calibrated sample, two's complement
  typedef logic signed [SMP_W-1:0] sample_t;
  // gain, 8192 is unity
  typedef logic signed [MUL_W-1:0] cal_mul_t;
  // offset in sample units
  typedef logic signed [SMP_W-1:0] cal_sum_t;
  // adc_clk cycles since reset
  typedef logic [31:0] ts_t;
  // keep one in dec samples, 0 acts as 1
  typedef logic [15:0] dec_t;
  // dropped samples, sticks at max
  typedef logic [15:0] ovf_cnt_t;

  ////////////////////////////////////////
  // calibration constants
  ////////////////////////////////////////

  // product back to sample scale
  localparam int CAL_SHIFT = 13;
  // saturation limits
  localparam sample_t SAMPLE_MAX = sample_t'(8191);
  localparam sample_t SAMPLE_MIN = sample_t'(-8192);

endpackage

`default_nettype wire

// ==== design/dma_readout.sv ====
/*
  sample readout port
  takes one word from the FIFO and hands it out over a four-phase
  req/ack handshake
*/

`default_nettype none

module dma_readout (
  input  wire                    adc_clk,
  input  wire                    top_rst,
  input  wire                    fifo_empty_i,
  input  wire acq_pkg::sample_t  fifo_sample_i,
  input  wire acq_pkg::ts_t      fifo_ts_i,
  output logic                   fifo_pop_o,
  output logic                   rd_req_o,
  input  wire                    rd_ack_i,
  output acq_pkg::sample_t       rd_sample_o,
  output acq_pkg::ts_t           rd_ts_o
);

  typedef enum logic [1:0] {
    idle,
    load,
    req_high,
    wait_ack_low
  } rd_state_t;

  rd_state_t state;

  // take the head while idle
  assign fifo_pop_o = (state == idle) && !fifo_empty_i;

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      state    <= idle;
      rd_req_o <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (!fifo_empty_i) begin
            state <= load;
          end
        end
        // word is in the output register now
        load: begin
          rd_req_o <= 1'b1;
          state    <= req_high;
        end
        req_high: begin
          if (rd_ack_i) begin
            rd_req_o <= 1'b0;
            state    <= wait_ack_low;
          end
        end
        // word ends when ack drops
        wait_ack_low: begin
          if (!rd_ack_i) begin
            state <= idle;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // output word register
  always_ff @(posedge adc_clk) begin
    if (fifo_pop_o) begin
      rd_sample_o <= fifo_sample_i;
      rd_ts_o     <= fifo_ts_i;
    end
  end

  ////////////////////////////////////////
  // handshake checks
  ////////////////////////////////////////

  a_data_stable: assert property (@(posedge adc_clk) disable iff (top_rst)
    (rd_req_o && $past(rd_req_o)) |-> ($stable(rd_sample_o) && $stable(rd_ts_o)));

  a_req_held: assert property (@(posedge adc_clk) disable iff (top_rst)
    (rd_req_o && !rd_ack_i) |=> rd_req_o);

endmodule

`default_nettype wire

// ==== design/scope_acq_top.sv ====
/*
  single channel acquisition top
  ADC calibration, sample FIFO and req/ack readout on adc_clk
*/

`default_nettype none

module scope_acq_top #(
  parameter int unsigned FIFO_DEPTH = 16
) (
  input  wire                    adc_clk,
  input  wire                    top_rst,
  input  wire [15:0]             adc_dat_i,
  input  wire                    acq_en_i,
  input  wire acq_pkg::dec_t     dec_i,
  input  wire acq_pkg::cal_mul_t cal_mul_i,
  input  wire acq_pkg::cal_sum_t cal_sum_i,
  input  wire                    rd_ack_i,
  output logic                   rd_req_o,
  output acq_pkg::sample_t       rd_sample_o,
  output acq_pkg::ts_t           rd_ts_o,
  output acq_pkg::ovf_cnt_t      ovf_cnt_o
);

  // calibrated sample strobe
  logic             smp_vld;
  acq_pkg::sample_t smp_data;
  acq_pkg::ts_t     smp_ts;
  // FIFO head
  logic             fifo_empty;
  acq_pkg::sample_t fifo_sample;
  acq_pkg::ts_t     fifo_ts;
  logic             fifo_pop;

  ////////////////////////////////////////
  // producer
  ////////////////////////////////////////

  adc_calib calib0 (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .adc_dat_i  (adc_dat_i),
    .acq_en_i   (acq_en_i),
    .dec_i      (dec_i),
    .cal_mul_i  (cal_mul_i),
    .cal_sum_i  (cal_sum_i),
    .smp_vld_o  (smp_vld),
    .smp_data_o (smp_data),
    .smp_ts_o   (smp_ts)
  );

  ////////////////////////////////////////
  // buffer and readout
  ////////////////////////////////////////

  acq_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fifo0 (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .wr_vld_i    (smp_vld),
    .wr_sample_i (smp_data),
    .wr_ts_i     (smp_ts),
    .rd_pop_i    (fifo_pop),
    .rd_empty_o  (fifo_empty),
    .rd_sample_o (fifo_sample),
    .rd_ts_o     (fifo_ts),
    .ovf_cnt_o   (ovf_cnt_o)
  );

  dma_readout readout0 (
    .adc_clk       (adc_clk),
    .top_rst       (top_rst),
    .fifo_empty_i  (fifo_empty),
    .fifo_sample_i (fifo_sample),
    .fifo_ts_i     (fifo_ts),
    .fifo_pop_o    (fifo_pop),
    .rd_req_o      (rd_req_o),
    .rd_ack_i      (rd_ack_i),
    .rd_sample_o   (rd_sample_o),
    .rd_ts_o       (rd_ts_o)
  );

endmodule

`default_nettype wire

// ==== scope_acq_top.f ====
common/acq_pkg.sv
adc_calib/adc_calib.sv
acq_fifo/acq_fifo.sv
design/dma_readout.sv
design/scope_acq_top.sv
verif/tb_scope_acq.sv

// ==== verif/scope_acq_trace.txt ====
# columns: name dec mul sum ack n, then n pairs of ADC word (hex) and expected sample
# ack 0 prompt, 1 random ack delays, 2 ack withheld until capture ends
# unity gain, zero offset
unity 1 8192 0 0 8
7ffc 0     0000 8191   fffc -8192  8000 -1
4000 4095  c000 -4097  7fff 0      048d 7900
# gain 1.5, offset 2000, both limits
gain_sat 1 12288 2000 0 8
0000 8191  fffc -8192  7ffc 2000   8000 1998
4000 8142  3f70 8191   c000 -4146  ea3c -8192
# running index, keep one in three, offset -100
decimate 3 8192 -100 0 12
0000 8091  0004 8090  0008 8089  000c 8088
0010 8087  0014 8086  0018 8085  001c 8084
0020 8083  0024 8082  0028 8081  002c 8080
# random ack delays
handshake 1 8192 0 1 10
8000 -1   8004 -2   8008 -3   800c -4   8010 -5
8014 -6   8018 -7   801c -8   8020 -9   8024 -10
# ack withheld, 17 kept and 7 dropped
overflow 1 8192 0 2 24
0100 8127  0104 8126  0108 8125  010c 8124
0110 8123  0114 8122  0118 8121  011c 8120
0120 8119  0124 8118  0128 8117  012c 8116
0130 8115  0134 8114  0138 8113  013c 8112
0140 8111  0144 8110  0148 8109  014c 8108
0150 8107  0154 8106  0158 8105  015c 8104

// ==== verif/tb_scope_acq.sv ====
/*
  testbench for the single channel acquisition top
  replays the trace into the ADC pins, plays the ack side of the
  readout port and checks samples, time stamps, handshake and overflow
*/

`default_nettype none

module tb_scope_acq;

  localparam int DEPTH = 16;
  localparam int MAX_TESTS = 8;
  localparam int MAX_WORDS = 128;
  // strobe 3 cycles after capture plus the FIFO write
  localparam int PIPE_LAT = 4;
  // idle cycles that show no extra word follows
  localparam int QUIET = 8;

  logic              adc_clk;
  logic              top_rst;
  logic [15:0]       adc_dat_i;
  logic              acq_en_i;
  acq_pkg::dec_t     dec_i;
  acq_pkg::cal_mul_t cal_mul_i;
  acq_pkg::cal_sum_t cal_sum_i;
  logic              rd_ack_i;
  logic              rd_req_o;
  acq_pkg::sample_t  rd_sample_o;
  acq_pkg::ts_t      rd_ts_o;
  acq_pkg::ovf_cnt_t ovf_cnt_o;

  // trace contents with the words of all tests in one flat array
  string       t_name [MAX_TESTS];
  int          t_dec [MAX_TESTS];
  int          t_mul [MAX_TESTS];
  int          t_sum [MAX_TESTS];
  int          t_ack [MAX_TESTS];
  int          t_n [MAX_TESTS];
  int          t_off [MAX_TESTS];
  logic [15:0] w_adc [MAX_WORDS];
  int          w_exp [MAX_WORDS];
  int          n_tests;

  // receiver side
  int               rx_smp [$];
  longint           rx_ts [$];
  logic             hold_ack;
  logic             rand_ack;
  int               phase;
  int               delay;
  acq_pkg::sample_t held_smp;
  acq_pkg::ts_t     held_ts;
  logic [31:0]      rng;

  string cur_name;
  int    err_cnt;
  int    cyc_limit;
  int    cycles;
  int    sum_len;

  scope_acq_top #(
    .FIFO_DEPTH (DEPTH)
  ) dut0 (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .adc_dat_i   (adc_dat_i),
    .acq_en_i    (acq_en_i),
    .dec_i       (dec_i),
    .cal_mul_i   (cal_mul_i),
    .cal_sum_i   (cal_sum_i),
    .rd_ack_i    (rd_ack_i),
    .rd_req_o    (rd_req_o),
    .rd_sample_o (rd_sample_o),
    .rd_ts_o     (rd_ts_o),
    .ovf_cnt_o   (ovf_cnt_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // 0..3 cycles in random mode and none otherwise
  task automatic pick_delay();
    if (rand_ack) begin
      rng = xorshift(rng);
      delay = int'(rng[1:0]);
    end else begin
      delay = 0;
    end
  endtask

  task automatic value_mismatch(input string what, input longint expv, input longint actv);
    $display("error %s: %s expected %0d, actual %0d", cur_name, what, expv, actv);
    err_cnt++;
  endtask

  task automatic protocol_fault(input string what);
    $display("%s: %s", cur_name, what);
    err_cnt++;
  endtask

  ////////////////////////////////////////
  // ack side of the four-phase port
  ////////////////////////////////////////

  // phase 0 idle, 1 req seen, 2 ack high, 3 ack held after req fell
  initial begin
    rd_ack_i = 1'b0;
    phase = 0;
    delay = 0;
    wait (top_rst == 1'b0);
    forever begin
      @(posedge adc_clk);
      #1;
      if (rd_req_o && (phase == 1 || phase == 2)) begin
        if (rd_sample_o !== held_smp) begin
          value_mismatch("sample under req", held_smp, rd_sample_o);
        end
        if (rd_ts_o !== held_ts) begin
          value_mismatch("time stamp under req", held_ts, rd_ts_o);
        end
      end
      case (phase)
        0: begin
          if (rd_req_o) begin
            held_smp = rd_sample_o;
            held_ts = rd_ts_o;
            rx_smp.push_back(int'(rd_sample_o));
            rx_ts.push_back(longint'(rd_ts_o));
            pick_delay();
            phase = 1;
          end
        end
        1: begin
          if (!hold_ack && delay == 0) begin
            rd_ack_i = 1'b1;
            phase = 2;
          end else if (!hold_ack) begin
            delay--;
          end
        end
        2: begin
          if (!rd_req_o) begin
            pick_delay();
            phase = 3;
          end
        end
        default: begin
          if (rd_req_o) begin
            protocol_fault("rd_req_o rose while rd_ack_i was still high");
          end
          if (delay == 0) begin
            rd_ack_i = 1'b0;
            phase = 0;
          end else begin
            delay--;
          end
        end
      endcase
    end
  end

  // limit known once the trace is read
  initial begin
    cycles = 0;
    wait (cyc_limit > 0);
    while (cycles <= cyc_limit) begin
      @(posedge adc_clk);
      cycles++;
    end
    $display("timeout: run did not end within %0d cycles", cyc_limit);
    $display("Simulation finished: FAIL");
    $finish;
  end

  ////////////////////////////////////////
  // trace replay and checks
  ////////////////////////////////////////

  initial begin
    int          fd;
    int          rc;
    int          k;
    int          i;
    int          off;
    int          d;
    int          m;
    int          s;
    int          a;
    int          n;
    int          e;
    int          dec;
    int          kept;
    int          exp_rx;
    int          ovf_base;
    int          quiet;
    int          fails;
    int          errs_before;
    logic [15:0] w;
    string       tok;
    string       line;
    top_rst = 1'b1;
    adc_dat_i = '0;
    acq_en_i = 1'b0;
    dec_i = acq_pkg::dec_t'(1);
    cal_mul_i = acq_pkg::cal_mul_t'(8192);
    cal_sum_i = '0;
    hold_ack = 1'b0;
    rand_ack = 1'b0;
    rng = 32'd98133;
    cur_name = "trace";
    err_cnt = 0;
    cyc_limit = 0;
    n_tests = 0;
    fails = 0;
    off = 0;
    sum_len = 0;

    fd = $fopen("verif/scope_acq_trace.txt", "r");
    if (fd == 0) begin
      protocol_fault("cannot open verif/scope_acq_trace.txt");
    end else begin
      rc = $fscanf(fd, "%s", tok);
      while (rc == 1 && n_tests < MAX_TESTS) begin
        if (tok.substr(0, 0) == "#") begin
          rc = $fgets(line, fd);
        end else begin
          rc = $fscanf(fd, "%d %d %d %d %d", d, m, s, a, n);
          t_name[n_tests] = tok;
          t_dec[n_tests] = (d == 0) ? 1 : d;
          t_mul[n_tests] = m;
          t_sum[n_tests] = s;
          t_ack[n_tests] = a;
          t_n[n_tests] = n;
          t_off[n_tests] = off;
          for (i = 0; i < n && off < MAX_WORDS; i++) begin
            rc = $fscanf(fd, "%h %d", w, e);
            w_adc[off] = w;
            w_exp[off] = e;
            off++;
          end
          sum_len += n * (t_dec[n_tests] + 8);
          n_tests++;
        end
        rc = $fscanf(fd, "%s", tok);
      end
      $fclose(fd);
    end
    if (n_tests == 0) begin
      protocol_fault("trace holds no tests");
    end
    cyc_limit = 4 * sum_len + 200;

    repeat (8) @(posedge adc_clk);
    #1;
    top_rst = 1'b0;

    for (k = 0; k < n_tests; k++) begin
      cur_name = t_name[k];
      errs_before = err_cnt;
      dec = t_dec[k];
      @(posedge adc_clk);
      #1;
      // settings stay fixed while acquisition runs
      dec_i = acq_pkg::dec_t'(dec);
      cal_mul_i = acq_pkg::cal_mul_t'(t_mul[k]);
      cal_sum_i = acq_pkg::cal_sum_t'(t_sum[k]);
      hold_ack = (t_ack[k] == 2);
      rand_ack = (t_ack[k] == 1);
      rx_smp.delete();
      rx_ts.delete();
      ovf_base = int'(ovf_cnt_o);
      for (i = 0; i < t_n[k]; i++) begin
        @(posedge adc_clk);
        #1;
        acq_en_i = 1'b1;
        adc_dat_i = w_adc[t_off[k] + i];
      end
      @(posedge adc_clk);
      #1;
      acq_en_i = 1'b0;

      // one word per dec and 17 words of storage while ack is withheld
      kept = (t_n[k] + dec - 1) / dec;
      exp_rx = (hold_ack && kept > DEPTH + 1) ? DEPTH + 1 : kept;
      repeat (PIPE_LAT) @(posedge adc_clk);
      #1;
      if (int'(ovf_cnt_o) - ovf_base != kept - exp_rx) begin
        value_mismatch("overflow count", kept - exp_rx, int'(ovf_cnt_o) - ovf_base);
      end
      hold_ack = 1'b0;

      while (rx_smp.size() < exp_rx) @(posedge adc_clk);
      quiet = 0;
      while (quiet < QUIET) begin
        @(negedge adc_clk);
        quiet = (phase == 0 && !rd_req_o) ? quiet + 1 : 0;
      end

      if (rx_smp.size() != exp_rx) begin
        value_mismatch("word count", exp_rx, rx_smp.size());
      end
      for (i = 0; i < rx_smp.size() && i < exp_rx; i++) begin
        e = w_exp[t_off[k] + i * dec];
        if (rx_smp[i] != e) begin
          value_mismatch($sformatf("word %0d", i), e, rx_smp[i]);
        end
        if (i > 0 && rx_ts[i] - rx_ts[i-1] != dec) begin
          value_mismatch($sformatf("ts step %0d", i), dec, rx_ts[i] - rx_ts[i-1]);
        end
      end

      if (err_cnt == errs_before) begin
        $display("test %s: ok, %0d words", cur_name, rx_smp.size());
      end else begin
        $display("test %s: %0d errors", cur_name, err_cnt - errs_before);
        fails++;
      end
    end

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             n_tests, n_tests - fails, fails, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
